/* design/systolic_pkg.sv */
`default_nettype none

package systolic_pkg;

	localparam int ELEM_W = 8; // one element and one accumulator
	localparam int DIM = 4; // array edge, lanes per word
	localparam int WORD_W = DIM * ELEM_W;
	localparam int IDX_W = 8;
	localparam int K_W = 4;
	localparam int ROW_W = $clog2(DIM); // result row select

	typedef logic [ELEM_W-1:0] elem_t;
	typedef elem_t lane_vec_t [DIM]; // one element per lane
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [IDX_W-1:0] idx_t;

	typedef enum logic [2:0] {
		SEQ_IDLE,
		SEQ_FEED,
		SEQ_DRAIN,
		SEQ_WRITE,
		SEQ_DONE
	} seq_state_t;

endpackage

`default_nettype wire

/* design/array_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface array_if;
	import systolic_pkg::*;

	lane_vec_t a_lane; // skewed data operands, row r
	lane_vec_t b_lane; // skewed weight operands, column j
	logic acc_clear;
	logic [ROW_W-1:0] row_sel;
	word_t row_data; // column 0 in the low byte

	modport feeder (
		output a_lane,
		output b_lane
	);

	modport array (
		input a_lane,
		input b_lane,
		input acc_clear,
		input row_sel,
		output row_data
	);

	modport seq (
		output acc_clear,
		output row_sel,
		input row_data
	);

endinterface

`default_nettype wire

/* design/pe.sv */
`timescale 1ns/1ns
`default_nettype none

module pe (
	input wire clk,
	input wire rst,
	input logic clear_i,
	input systolic_pkg::elem_t data_i,
	input systolic_pkg::elem_t weight_i,
	output systolic_pkg::elem_t data_o,
	output systolic_pkg::elem_t weight_o,
	output systolic_pkg::elem_t acc_o
);
	import systolic_pkg::*;

	elem_t acc_q;
	elem_t prod;

	assign prod = data_i * weight_i; // wraps at ELEM_W
	assign acc_o = acc_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			data_o <= '0;
			weight_o <= '0;
			acc_q <= '0;
		end else begin
			data_o <= data_i; // to the right neighbour
			weight_o <= weight_i; // to the PE below
			if (clear_i) begin
				acc_q <= '0;
			end else begin
				acc_q <= acc_q + prod;
			end
		end
	end

endmodule

`default_nettype wire

/* design/skew_feeder.sv */
`timescale 1ns/1ns
`default_nettype none

module skew_feeder (
	input wire clk,
	input wire rst,
	input logic feed_en_i,
	input systolic_pkg::word_t a_word_i,
	input systolic_pkg::word_t b_word_i,
	array_if.feeder bus
);
	import systolic_pkg::*;

	lane_vec_t a_in;
	lane_vec_t b_in;

	// lane 0 sits in the top byte
	always_comb begin
		for (int r = 0; r < DIM; r++) begin
			a_in[r] = feed_en_i ? a_word_i[WORD_W-1-r*ELEM_W -: ELEM_W] : '0;
			b_in[r] = feed_en_i ? b_word_i[WORD_W-1-r*ELEM_W -: ELEM_W] : '0;
		end
	end

	for (genvar r = 0; r < DIM; r++) begin : g_lane
		if (r == 0) begin : g_direct
			assign bus.a_lane[r] = a_in[r]; // no delay on lane 0
			assign bus.b_lane[r] = b_in[r];
		end else begin : g_delay
			elem_t a_sr [r];
			elem_t b_sr [r];

			always_ff @(posedge clk or posedge rst) begin
				if (rst) begin
					for (int i = 0; i < r; i++) begin
						a_sr[i] <= '0;
						b_sr[i] <= '0;
					end
				end else begin
					a_sr[0] <= a_in[r];
					b_sr[0] <= b_in[r];
					for (int i = 1; i < r; i++) begin
						a_sr[i] <= a_sr[i-1];
						b_sr[i] <= b_sr[i-1];
					end
				end
			end

			assign bus.a_lane[r] = a_sr[r-1]; // r cycles late
			assign bus.b_lane[r] = b_sr[r-1];
		end
	end

endmodule

`default_nettype wire

/* design/pe_array.sv */
`timescale 1ns/1ns
`default_nettype none

module pe_array (
	input wire clk,
	input wire rst,
	array_if.array bus
);
	import systolic_pkg::*;

	// column DIM of d_net and row DIM of w_net leave the grid
	elem_t d_net [DIM][DIM+1];
	elem_t w_net [DIM+1][DIM];
	elem_t acc [DIM][DIM];

	for (genvar r = 0; r < DIM; r++) begin : g_edge_a
		assign d_net[r][0] = bus.a_lane[r];
	end

	for (genvar c = 0; c < DIM; c++) begin : g_edge_b
		assign w_net[0][c] = bus.b_lane[c];
	end

	for (genvar r = 0; r < DIM; r++) begin : g_row
		for (genvar c = 0; c < DIM; c++) begin : g_col
			pe pe_inst (
				.clk(clk),
				.rst(rst),
				.clear_i(bus.acc_clear),
				.data_i(d_net[r][c]),
				.weight_i(w_net[r][c]),
				.data_o(d_net[r][c+1]),
				.weight_o(w_net[r+1][c]),
				.acc_o(acc[r][c])
			);
		end
	end

	// selected result row, column 0 in the low byte
	always_comb begin
		bus.row_data = '0;
		for (int c = 0; c < DIM; c++) begin
			bus.row_data[c*ELEM_W +: ELEM_W] = acc[bus.row_sel][c];
		end
	end

endmodule

`default_nettype wire

/* design/array_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module array_sequencer #(
	parameter int MAX_K = 9
) (
	input wire clk,
	input wire rst,
	input logic start_i,
	input logic [systolic_pkg::K_W-1:0] k_i,
	array_if.seq bus,
	output logic feed_en_o,
	output systolic_pkg::idx_t rd_index_o,
	output logic out_we_o,
	output systolic_pkg::idx_t out_index_o,
	output systolic_pkg::word_t out_wdata_o,
	output logic done_o
);
	import systolic_pkg::*;

	localparam logic [K_W-1:0] K_MAX = K_W'(MAX_K);
	// last product reaches PE(DIM-1,DIM-1) after 2*(DIM-1) hops
	localparam logic [K_W-1:0] DRAIN_LAST = K_W'(2 * (DIM - 1));
	localparam logic [K_W-1:0] WRITE_LAST = K_W'(DIM - 1);

	seq_state_t state_q;
	seq_state_t state_d;
	logic [K_W-1:0] cnt_q; // cycle within the current phase
	logic [K_W-1:0] k_q;
	logic [K_W-1:0] k_clamp;
	logic phase_last;

	always_comb begin
		if (k_i > K_MAX) begin
			k_clamp = K_MAX;
		end else if (k_i == '0) begin
			k_clamp = K_W'(1); // at least one feed cycle
		end else begin
			k_clamp = k_i;
		end
	end

	always_comb begin
		case (state_q)
			SEQ_FEED: phase_last = (cnt_q == k_q - K_W'(1));
			SEQ_DRAIN: phase_last = (cnt_q == DRAIN_LAST);
			SEQ_WRITE: phase_last = (cnt_q == WRITE_LAST);
			default: phase_last = 1'b1;
		endcase
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			SEQ_IDLE: begin
				if (start_i) begin
					state_d = SEQ_FEED;
				end
			end
			SEQ_FEED: begin
				if (phase_last) begin
					state_d = SEQ_DRAIN;
				end
			end
			SEQ_DRAIN: begin
				if (phase_last) begin
					state_d = SEQ_WRITE;
				end
			end
			SEQ_WRITE: begin
				if (phase_last) begin
					state_d = SEQ_DONE;
				end
			end
			default: state_d = SEQ_IDLE; // done lasts one cycle
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q <= SEQ_IDLE;
			cnt_q <= '0;
			k_q <= '0;
		end else begin
			state_q <= state_d;
			if (state_q == SEQ_IDLE || state_d != state_q) begin
				cnt_q <= '0;
			end else begin
				cnt_q <= cnt_q + K_W'(1);
			end
			if (state_q == SEQ_IDLE && start_i) begin
				k_q <= k_clamp; // busy runs keep the old K
			end
		end
	end

	assign feed_en_o = (state_q == SEQ_FEED);
	assign rd_index_o = feed_en_o ? idx_t'(cnt_q) : '0;

	assign bus.row_sel = cnt_q[ROW_W-1:0];
	assign out_we_o = (state_q == SEQ_WRITE);
	assign out_index_o = out_we_o ? idx_t'(cnt_q) : '0;
	assign out_wdata_o = out_we_o ? bus.row_data : '0;

	assign done_o = (state_q == SEQ_DONE);
	assign bus.acc_clear = done_o; // ready for the next run

endmodule

`default_nettype wire

/* design/systolic_top.sv */
`timescale 1ns/1ns
`default_nettype none

module systolic_top #(
	parameter int MAX_K = 9
) (
	input wire clk,
	input wire rst,
	input logic start_i,
	input logic [systolic_pkg::K_W-1:0] k_i,
	input systolic_pkg::word_t a_rdata_i, // column t of A
	input systolic_pkg::word_t b_rdata_i, // row t of B
	output systolic_pkg::idx_t rd_index_o,
	output logic out_we_o,
	output systolic_pkg::idx_t out_index_o,
	output systolic_pkg::word_t out_wdata_o,
	output logic done_o
);

	array_if bus_if ();

	logic feed_en;

	skew_feeder skew_feeder_inst (
		.clk(clk),
		.rst(rst),
		.feed_en_i(feed_en),
		.a_word_i(a_rdata_i),
		.b_word_i(b_rdata_i),
		.bus(bus_if.feeder)
	);

	pe_array pe_array_inst (
		.clk(clk),
		.rst(rst),
		.bus(bus_if.array)
	);

	array_sequencer #(
		.MAX_K(MAX_K)
	) array_sequencer_inst (
		.clk(clk),
		.rst(rst),
		.start_i(start_i),
		.k_i(k_i),
		.bus(bus_if.seq),
		.feed_en_o(feed_en),
		.rd_index_o(rd_index_o),
		.out_we_o(out_we_o),
		.out_index_o(out_index_o),
		.out_wdata_o(out_wdata_o),
		.done_o(done_o)
	);

endmodule

`default_nettype wire

/* sim/tb_systolic.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_systolic;
	import systolic_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int MAX_K = 9;
	localparam int NUM_RUNS = 40;
	localparam int IDLE_CYCLES = 50;
	localparam int DRAIN_CYCLES = 2 * (DIM - 1) + 1;
	localparam int WAIT_SLACK = 20; // extra cycles before a wait gives up
	localparam logic [31:0] SEED = 32'h6f5c_da04;

	logic clk;
	logic rst;
	logic start_i;
	logic [K_W-1:0] k_i;
	word_t a_rdata_i;
	word_t b_rdata_i;
	idx_t rd_index_o;
	logic out_we_o;
	idx_t out_index_o;
	word_t out_wdata_o;
	logic done_o;

	logic [31:0] rng_state;
	elem_t a_mat [DIM][MAX_K]; // A[i][t]
	elem_t b_mat [MAX_K][DIM]; // B[t][j]

	systolic_top #(
		.MAX_K(MAX_K)
	) systolic_top_inst (
		.clk(clk),
		.rst(rst),
		.start_i(start_i),
		.k_i(k_i),
		.a_rdata_i(a_rdata_i),
		.b_rdata_i(b_rdata_i),
		.rd_index_o(rd_index_o),
		.out_we_o(out_we_o),
		.out_index_o(out_index_o),
		.out_wdata_o(out_wdata_o),
		.done_o(done_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// combinational buffers, column t of A and row t of B, lane 0 in the top byte
	always_comb begin
		int idx;
		idx = int'(rd_index_o);
		a_rdata_i = '0;
		b_rdata_i = '0;
		if (idx < MAX_K) begin
			for (int l = 0; l < DIM; l++) begin
				a_rdata_i[WORD_W-1-l*ELEM_W -: ELEM_W] = a_mat[l][idx];
				b_rdata_i[WORD_W-1-l*ELEM_W -: ELEM_W] = b_mat[idx][l];
			end
		end
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			abort_run($sformatf("ERROR %s: expected %h, actual %h", name, expected, actual));
		end
	endtask

	task automatic check_index(input string name, input idx_t expected, input idx_t actual);
		if (actual !== expected) begin
			abort_run($sformatf("ERROR %s: expected %0d, actual %0d", name, expected, actual));
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			abort_run($sformatf("ERROR %s: expected %b, actual %b", name, expected, actual));
		end
	endtask

	// whole buffer is refilled, so entries past K hold fresh junk
	task automatic fill_buffers();
		for (int t = 0; t < MAX_K; t++) begin
			for (int l = 0; l < DIM; l++) begin
				a_mat[l][t] = elem_t'(next_random() >> 24);
				b_mat[t][l] = elem_t'(next_random() >> 24);
			end
		end
	endtask

	// C[r][j] mod 256, column 0 in the low byte
	function automatic word_t expected_row(input int r, input int k);
		word_t row;
		int sum;
		row = '0;
		for (int j = 0; j < DIM; j++) begin
			sum = 0;
			for (int t = 0; t < k; t++) begin
				sum = (sum + int'(a_mat[r][t]) * int'(b_mat[t][j])) % 256;
			end
			row[j*ELEM_W +: ELEM_W] = elem_t'(sum);
		end
		return row;
	endfunction

	task automatic do_run(input int run, input int k, input bit poke, input int poke_at);
		int waited;
		int writes;
		@(posedge clk);
		start_i <= 1'b1;
		k_i <= K_W'(k);
		@(posedge clk); // start is sampled here
		start_i <= 1'b0;
		@(negedge clk);
		waited = 0;
		while (!out_we_o) begin
			if (waited > k + DRAIN_CYCLES + WAIT_SLACK) begin
				abort_run($sformatf("run %0d: no write strobe after %0d cycles", run, waited));
			end
			if (waited < k) begin
				check_index($sformatf("run %0d feed index", run), idx_t'(waited), rd_index_o);
			end
			check_flag($sformatf("run %0d done before writes", run), 1'b0, done_o);
			@(posedge clk);
			if (poke && waited == poke_at) begin
				start_i <= 1'b1; // should be ignored, sequencer is busy
				k_i <= K_W'((k % MAX_K) + 1);
			end else begin
				start_i <= 1'b0;
			end
			@(negedge clk);
			waited++;
		end
		check_index($sformatf("run %0d first write latency", run),
			idx_t'(k + DRAIN_CYCLES), idx_t'(waited));
		writes = 0;
		while (out_we_o) begin
			if (writes >= DIM) begin
				abort_run($sformatf("run %0d: write strobe stayed high past %0d rows", run, DIM));
			end
			check_index($sformatf("run %0d write index", run), idx_t'(writes), out_index_o);
			check_word($sformatf("run %0d row %0d", run, writes),
				expected_row(writes, k), out_wdata_o);
			check_flag($sformatf("run %0d done during writes", run), 1'b0, done_o);
			writes++;
			@(negedge clk);
		end
		check_index($sformatf("run %0d write count", run), idx_t'(DIM), idx_t'(writes));
		check_flag($sformatf("run %0d done after last write", run), 1'b1, done_o);
		@(negedge clk);
		check_flag($sformatf("run %0d done width", run), 1'b0, done_o);
		check_flag($sformatf("run %0d write after done", run), 1'b0, out_we_o);
	endtask

	initial begin
		int k;
		bit poke;
		int poke_at;
		rst = 1'b1;
		start_i = 1'b0;
		k_i = '0;
		rng_state = SEED;
		for (int t = 0; t < MAX_K; t++) begin
			for (int l = 0; l < DIM; l++) begin
				a_mat[l][t] = '0;
				b_mat[t][l] = '0;
			end
		end
		repeat (16) @(posedge clk);
		rst <= 1'b0;

		for (int i = 0; i < IDLE_CYCLES; i++) begin
			@(negedge clk);
			check_flag("idle write strobe", 1'b0, out_we_o);
			check_flag("idle done", 1'b0, done_o);
		end

		for (int run = 0; run < NUM_RUNS; run++) begin
			k = 1 + int'(next_random() % 32'd9);
			poke = (run % 4 == 3);
			// at least one more cycle of feed or drain follows the extra pulse
			poke_at = int'(next_random() % 32'(k + DRAIN_CYCLES - 1));
			fill_buffers();
			do_run(run, k, poke, poke_at);
		end

		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
design/systolic_pkg.sv
design/array_if.sv
design/pe.sv
design/skew_feeder.sv
design/pe_array.sv
design/array_sequencer.sv
design/systolic_top.sv
sim/tb_systolic.sv

/* Makefile */
TOP = tb_systolic

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --top-module $(TOP) -f src.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
